// ==== src/corePkg.sv ====
package corePkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIdx_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [1:0]  srcSel_t;
  typedef logic [1:0]  wbSel_t;
  typedef logic [2:0]  aluFn_t;

  // Opcodes, octal as in the instruction map
  localparam opcode_t opAdd  = 6'o00;
  localparam opcode_t opAddI = 6'o10;
  localparam opcode_t opLog  = 6'o40; // Low two bits pick and, or, xor
  localparam opcode_t opLogI = 6'o50;
  localparam opcode_t opSrl  = 6'o44;
  localparam opcode_t opMov  = 6'o45;
  localparam opcode_t opLw   = 6'o62;
  localparam opcode_t opSw   = 6'o66;

  // Operand sources
  localparam srcSel_t srcRf  = 2'd0;
  localparam srcSel_t srcEx  = 2'd1;
  localparam srcSel_t srcWb  = 2'd2;
  localparam srcSel_t srcImm = 2'd3;

  // Writeback sources
  localparam wbSel_t wbAlu  = 2'd0;
  localparam wbSel_t wbMem  = 2'd2;
  localparam wbSel_t wbNone = 2'd3;

  // ALU functions
  localparam aluFn_t fnAdd   = 3'd0;
  localparam aluFn_t fnLog   = 3'd1;
  localparam aluFn_t fnSrl   = 3'd2;
  localparam aluFn_t fnPassA = 3'd3;

endpackage

// ==== src/pipeCtrl.sv ====
`timescale 1ns/1ps

module pipeCtrl import corePkg::*; (
  input  logic    gclk,
  input  logic    arstN,
  input  logic    advance,
  input  word_t   inst,
  output srcSel_t srcSelA,
  output srcSel_t srcSelB,
  output srcSel_t srcSelStore,
  output aluFn_t  aluFn,
  output logic [1:0] logicOp,
  output logic    memWe,
  output wbSel_t  wbSel,
  output regIdx_t wbAddr,
  output logic    wbEn,
  output regIdx_t exDst
);

  opcode_t opc;
  regIdx_t rdField;
  regIdx_t raField;
  regIdx_t rbField;

  logic isImm;
  logic isAdd;
  logic isLog;
  logic isSrl;
  logic isMov;
  logic isLoad;
  logic isStore;

  aluFn_t decFn;
  wbSel_t decWbSel;

  wbSel_t exWbSel; // Writeback source of the instruction in execute
  logic   exWbEn;

  assign opc     = inst[31:26];
  assign rdField = inst[25:21];
  assign raField = inst[20:16];
  assign rbField = inst[15:11];

  // Opcode classes
  assign isImm   = opc[3];
  assign isAdd   = (opc == opAdd) || (opc == opAddI);
  assign isLog   = (opc[5:2] == opLog[5:2]) || (opc[5:2] == opLogI[5:2]);
  assign isSrl   = (opc == opSrl);
  assign isMov   = (opc == opMov);
  assign isLoad  = (opc == opLw);
  assign isStore = (opc == opSw);

  always_comb begin
    if (isMov)      decFn = fnPassA;
    else if (isSrl) decFn = fnSrl;
    else if (isLog) decFn = fnLog;
    else            decFn = fnAdd; // Add, and address for load and store
  end

  always_comb begin
    if (isStore)     decWbSel = wbNone;
    else if (isLoad) decWbSel = wbMem;
    else if (isAdd || isLog || isSrl || isMov) decWbSel = wbAlu;
    else             decWbSel = wbNone; // Unknown opcodes write nothing
  end

  // Newest producer wins; a load still in execute is not forwarded
  function automatic srcSel_t fwdSel(input regIdx_t idx);
    if ((exDst == idx) && (exDst != '0) && (exWbSel == wbAlu))
      return srcEx;
    else if (wbEn && (wbAddr == idx))
      return srcWb;
    else
      return srcRf;
  endfunction

  always_comb begin
    srcSelA     = fwdSel(raField);
    srcSelB     = isImm ? srcImm : fwdSel(rbField);
    srcSelStore = fwdSel(rdField); // Store data comes from the D field
  end

  assign exWbEn = (exWbSel != wbNone) && (exDst != '0);

  // Decode to execute
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      aluFn   <= fnAdd;
      logicOp <= '0;
      memWe   <= 1'b0;
      exDst   <= '0;
      exWbSel <= wbAlu;
    end else if (advance) begin
      aluFn   <= decFn;
      logicOp <= opc[1:0];
      memWe   <= isStore;
      exDst   <= rdField;
      exWbSel <= decWbSel;
    end
  end

  // Execute to writeback
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      wbSel  <= wbAlu;
      wbAddr <= '0;
      wbEn   <= 1'b0;
    end else if (advance) begin
      wbSel  <= exWbSel;
      wbAddr <= exDst;
      wbEn   <= exWbEn;
    end
  end

  // Register 0 must never show up as a live writeback
  wbNotZero: assert property (@(posedge gclk) disable iff (!arstN)
    wbEn |-> (wbAddr != '0));

  storeNoWb: assert property (@(posedge gclk) disable iff (!arstN)
    memWe |-> !exWbEn);

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile import corePkg::*; (
  input  logic    gclk,
  input  logic    arstN,
  input  logic    advance,
  input  regIdx_t rdAddrA,
  input  regIdx_t rdAddrB,
  input  regIdx_t rdAddrD,
  output word_t   rdDataA,
  output word_t   rdDataB,
  output word_t   rdDataD,
  input  logic    wrEn,
  input  regIdx_t wrAddr,
  input  word_t   wrData
);

  word_t regs [1:31]; // No storage behind register 0

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && advance && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Asynchronous reads, register 0 is hardwired
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];
  assign rdDataD = (rdAddrD == '0) ? '0 : regs[rdAddrD];

  // Writeback control upstream keeps register 0 out of the write port
  noZeroWrite: assert property (@(posedge gclk) disable iff (!arstN)
    wrEn |-> (wrAddr != '0));

endmodule

// ==== src/operandSel.sv ====
`timescale 1ns/1ps

module operandSel import corePkg::*; (
  input  srcSel_t srcSelA,
  input  srcSel_t srcSelB,
  input  srcSel_t srcSelStore,
  input  word_t   rfA,
  input  word_t   rfB,
  input  word_t   rfD,
  input  word_t   exResult,
  input  word_t   wbData,
  input  word_t   inst,
  output word_t   opA,
  output word_t   opB,
  output word_t   storeData
);

  word_t immWord;

  // B field and alternate field, zero extended
  assign immWord = {16'h0000, inst[15:0]};

  function automatic word_t pick(input srcSel_t sel, input word_t rfVal);
    word_t val;
    case (sel)
      srcEx:   val = exResult;
      srcWb:   val = wbData;
      srcImm:  val = immWord;
      default: val = rfVal;
    endcase
    return val;
  endfunction

  always_comb begin
    opA       = pick(srcSelA, rfA);
    opB       = pick(srcSelB, rfB);
    storeData = pick(srcSelStore, rfD); // Never immediate
  end

endmodule

// ==== src/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit import corePkg::*; #(
  parameter int ramDepthLog2 = 6
) (
  input  logic   gclk,
  input  logic   arstN,
  input  logic   advance,
  input  word_t  opA,
  input  word_t  opB,
  input  word_t  storeData,
  input  aluFn_t aluFn,
  input  logic [1:0] logicOp,
  output word_t  result,
  output logic [ramDepthLog2-1:0] memAddr,
  output word_t  memData
);

  word_t exA;
  word_t exB;
  word_t exStore;
  word_t sum;
  word_t logicRes;

  // Operands enter execute with the control from pipeCtrl
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      exA     <= '0;
      exB     <= '0;
      exStore <= '0;
    end else if (advance) begin
      exA     <= opA;
      exB     <= opB;
      exStore <= storeData;
    end
  end

  assign sum = exA + exB;

  always_comb begin
    case (logicOp)
      2'd1:    logicRes = exA | exB;
      2'd2:    logicRes = exA ^ exB;
      default: logicRes = exA & exB; // Code 3 unused
    endcase
  end

  always_comb begin
    case (aluFn)
      fnLog:   result = logicRes;
      fnSrl:   result = exA >> 1;
      fnPassA: result = exA;
      default: result = sum;
    endcase
  end

  assign memAddr = sum[ramDepthLog2+1:2]; // Word index
  assign memData = exStore;

endmodule

// ==== src/dataRam.sv ====
`timescale 1ns/1ps

module dataRam import corePkg::*; #(
  parameter int ramDepthLog2 = 6
) (
  input  logic  gclk,
  input  logic  we,
  input  logic [ramDepthLog2-1:0] addr,
  input  word_t wrData,
  output word_t rdData,
  input  logic  advance
);

  localparam int depth = 2 ** ramDepthLog2;

  word_t mem [depth];

  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge gclk) begin
    if (we && advance) begin
      mem[addr] <= wrData;
    end
  end

  // Read data lands with the load in writeback
  always_ff @(posedge gclk) begin
    if (advance) begin
      rdData <= mem[addr];
    end
  end

endmodule

// ==== src/execCore.sv ====
`timescale 1ns/1ps

module execCore import corePkg::*; #(
  parameter int ramDepthLog2 = 6
) (
  input  logic    gclk,
  input  logic    arstN,
  input  logic    advance,
  input  word_t   inst,
  output word_t   wbData,
  output regIdx_t wbAddr,
  output logic    wbEn
);

  srcSel_t srcSelA, srcSelB, srcSelStore;
  aluFn_t  aluFn;
  logic [1:0] logicOp;
  logic    memWe;
  wbSel_t  wbSel;
  word_t   rfA, rfB, rfD;
  word_t   opA, opB, storeData;
  word_t   exResult;
  logic [ramDepthLog2-1:0] memAddr;
  word_t   memData;
  word_t   ramRdData;
  word_t   wbResult;

  pipeCtrl uCtrl (.gclk, .arstN, .advance, .inst, .srcSelA, .srcSelB, .srcSelStore,
    .aluFn, .logicOp, .memWe, .wbSel, .wbAddr, .wbEn, .exDst());

  regFile uRegs (.gclk, .arstN, .advance, .rdAddrA(inst[20:16]), .rdAddrB(inst[15:11]),
    .rdAddrD(inst[25:21]), .rdDataA(rfA), .rdDataB(rfB), .rdDataD(rfD),
    .wrEn(wbEn), .wrAddr(wbAddr), .wrData(wbData));

  operandSel uOps (.srcSelA, .srcSelB, .srcSelStore, .rfA, .rfB, .rfD, .exResult,
    .wbData, .inst, .opA, .opB, .storeData);

  aluUnit #(.ramDepthLog2(ramDepthLog2)) uAlu (.gclk, .arstN, .advance, .opA, .opB,
    .storeData, .aluFn, .logicOp, .result(exResult), .memAddr, .memData);

  dataRam #(.ramDepthLog2(ramDepthLog2)) uRam (.gclk, .we(memWe), .addr(memAddr),
    .wrData(memData), .rdData(ramRdData), .advance);

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN)       wbResult <= '0;
    else if (advance) wbResult <= exResult; // ALU result into writeback
  end

  assign wbData = (wbSel == wbMem) ? ramRdData : wbResult;

endmodule

// ==== dv/execCoreTb.sv ====
`timescale 1ns/1ps

module execCoreTb import corePkg::*; ();

  localparam int ramDepthLog2 = 6;

  logic    gclk;
  logic    arstN;
  logic    advance;
  word_t   inst;
  word_t   wbData;
  regIdx_t wbAddr;
  logic    wbEn;

  word_t   regs [32];               // Reference register file
  word_t   mem [2**ramDepthLog2];   // Reference data memory
  logic [37:0] expQ [$];            // Entries {en, addr, data} with writeback at the head
  logic [37:0] pend;
  logic    expEn;
  regIdx_t expAddr;
  word_t   expData;
  opcode_t opList [12];
  integer  seed = 96537;
  int      errCount = 0;
  int      expWrites = 0;
  int      seenWrites = 0;
  int      testErrBase = 0;
  int      testCount = 0;

  execCore #(.ramDepthLog2(ramDepthLog2)) u_dut (.gclk, .arstN, .advance, .inst, .wbData,
    .wbAddr, .wbEn);

  initial begin
    gclk = 1'b0;
    forever #50 gclk = ~gclk;
  end

  // One entry per stage after decode
  always @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      expQ.delete();
      expQ.push_back('0);
      expQ.push_back('0);
    end else if (advance) begin
      if (wbEn) seenWrites++; // Entry leaving writeback commits here
      expQ.push_back(pend);
      void'(expQ.pop_front());
    end
    {expEn, expAddr, expData} = expQ[0];
  end

  task automatic reportMismatch(input string sig, input word_t expVal, input word_t actVal);
    $display("mismatch at time %0t: %s expected %h actual %h", $time, sig, expVal, actVal);
    errCount++;
  endtask

  task automatic noteFailure(input string what);
    $display("%s at time %0t", what, $time);
    errCount++;
  endtask

  enChk: assert property (@(negedge gclk) disable iff (!arstN) wbEn == expEn)
    else reportMismatch("wbEn", expEn, wbEn);
  addrChk: assert property (@(negedge gclk) disable iff (!arstN) expEn |-> wbAddr == expAddr)
    else reportMismatch("wbAddr", expAddr, wbAddr);
  dataChk: assert property (@(negedge gclk) disable iff (!arstN) expEn |-> wbData == expData)
    else reportMismatch("wbData", expData, wbData);
  rstQuiet: assert property (@(negedge gclk) !arstN |-> !wbEn)
    else noteFailure("wbEn went high during reset");
  // A frozen pipeline shows no new writeback
  holdChk: assert property (@(posedge gclk) disable iff (!arstN)
    !advance |=> $stable(wbEn) && $stable(wbAddr) && $stable(wbData))
    else noteFailure("writeback changed while advance was low");

  function automatic word_t encR(opcode_t op, regIdx_t rd, regIdx_t ra, regIdx_t rb);
    return {op, rd, ra, rb, 11'd0};
  endfunction

  function automatic word_t encI(opcode_t op, regIdx_t rd, regIdx_t ra, logic [15:0] imm);
    return {op, rd, ra, imm};
  endfunction

  // In-order reference model filling pend for the next advance edge
  task automatic model(input word_t w);
    opcode_t op;
    regIdx_t rd;
    word_t   a;
    word_t   b;
    word_t   sum;
    word_t   res;
    logic    en;
    op  = w[31:26];
    rd  = w[25:21];
    a   = regs[w[20:16]];
    b   = op[3] ? {16'h0000, w[15:0]} : regs[w[15:11]];
    sum = a + b;
    res = '0;
    en  = (rd != '0);
    case (op)
      opAdd, opAddI:                   res = sum;
      opLog, opLogI:                   res = a & b;
      opLog | 6'o1, opLogI | 6'o1:     res = a | b;
      opLog | 6'o2, opLogI | 6'o2:     res = a ^ b;
      opSrl:                           res = a >> 1;
      opMov:                           res = a;
      opLw:                            res = mem[sum[ramDepthLog2+1:2]];
      default: begin
        if (op == opSw) mem[sum[ramDepthLog2+1:2]] = regs[rd];
        en = 1'b0; // Stores and unknown codes write nothing
      end
    endcase
    if (en) begin
      regs[rd] = res;
      expWrites++;
    end
    pend = {en, rd, en ? res : 32'h0};
  endtask

  task automatic issue(input word_t w);
    @(negedge gclk);
    inst    = w;
    advance = 1'b1;
    model(w);
  endtask

  task automatic stall(input int n);
    repeat (n) begin
      @(negedge gclk);
      advance = 1'b0;
    end
  endtask

  // Only r0 to r7 so that operands collide often
  task automatic randomRun(input int n, input int nOps, input bit withStalls);
    word_t w;
    logic [31:0] r;
    repeat (n) begin
      r = $random(seed);
      w = {opList[$unsigned($random(seed)) % nOps], 2'b00, r[2:0], 2'b00, r[5:3],
           2'b00, r[8:6], r[20:10]};
      issue(w);
      if (w[31:26] == opLw) issue('0); // Spacer before any use of the load
      if (withStalls && ($unsigned($random(seed)) % 3 == 0))
        stall(1 + $unsigned($random(seed)) % 3);
    end
  endtask

  task automatic closeTest(input string name);
    int tries;
    tries = 0;
    repeat (3) issue('0);
    while ((seenWrites != expWrites) && (tries < 8)) begin
      issue('0);
      tries++;
    end
    if (seenWrites != expWrites) begin
      $display("timeout in %s: %0d of %0d writebacks seen", name, seenWrites, expWrites);
      errCount++;
    end
    testCount++;
    $display("test %s finished, %0d errors", name, errCount - testErrBase);
    testErrBase = errCount;
  endtask

  initial begin
    arstN   = 1'b0;
    advance = 1'b0;
    inst    = '0;
    pend    = '0;
    opList  = '{opAdd, opAddI, opLog, opLog | 6'o1, opLog | 6'o2, opLogI, opLogI | 6'o1,
                opLogI | 6'o2, opSrl, opMov, opLw, opSw};
    foreach (regs[i]) regs[i] = '0;
    foreach (mem[i]) mem[i] = '0;
    repeat (3) @(posedge gclk);
    @(negedge gclk);
    arstN = 1'b1;

    stall(2);
    issue(encI(opAddI, 5'd1, 5'd0, 16'h0011));
    closeTest("reset");

    for (int r = 1; r < 8; r++) issue(encI(opAddI, 5'(r), 5'd0, 16'($random(seed))));
    for (int k = 0; k < 10; k++)
      issue({opList[k], 5'(1 + k % 7), 5'((k + 1) % 8), 5'((k + 3) % 8), 11'($random(seed))});
    randomRun(20, 10, 1'b0);
    closeTest("aluOps");

    repeat (3) issue(encI(opAddI, 5'd3, 5'd3, 16'h0101)); // Distance one on A
    issue(encR(opAdd, 5'd4, 5'd3, 5'd2));
    issue(encR(opLog | 6'o2, 5'd5, 5'd1, 5'd3));          // Distance two on B
    issue(encR(opSrl, 5'd6, 5'd4, 5'd0));
    issue(encR(opMov, 5'd7, 5'd6, 5'd0));
    closeTest("forwarding");

    issue(encI(opAddI, 5'd5, 5'd0, 16'hbeef));
    issue(encR(opSw, 5'd5, 5'd1, 5'd2)); // Store data from execute
    issue('0);
    issue(encR(opLw, 5'd6, 5'd1, 5'd2));
    issue('0);
    issue(encR(opAdd, 5'd7, 5'd6, 5'd6));
    closeTest("storeLoad");

    issue(encI(opAddI, 5'd0, 5'd1, 16'h0055));
    issue(encR(opAdd, 5'd0, 5'd2, 5'd3));
    issue(encR(opLog | 6'o1, 5'd4, 5'd0, 5'd0));
    issue(encI(opAddI, 5'd5, 5'd0, 16'h0007));
    closeTest("regZero");

    randomRun(40, 12, 1'b1);
    closeTest("stall");

    $display("tests %0d, writebacks %0d, errors %0d", testCount, seenWrites, errCount);
    if (errCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
src/corePkg.sv
src/pipeCtrl.sv
src/regFile.sv
src/operandSel.sv
src/aluUnit.sv
src/dataRam.sv
src/execCore.sv
dv/execCoreTb.sv
